/* dv/exec_unit_props.sv */
// Writeback protocol properties
`default_nettype none
`timescale 1ns/100ps

module exec_unit_props import mcalu_pkg::*; #(
  parameter int robid_w = 7,
  parameter int rd_w    = 6
) (
  input logic               clk,
  input logic               rst_n,
  input logic               flush,
  input logic               stall,
  input logic               wb_stall,
  input logic               wb_valid,
  input logic [robid_w-1:0] wb_robid,
  input logic [rd_w-1:0]    wb_rd,
  input logic [xlen-1:0]    wb_result,
  input logic               mcalu_valid
);

  int fails = 0;

  reset_idle: assert property (@(posedge clk)
    !rst_n |-> !stall && !wb_valid && !mcalu_valid)
    else begin
      $error("stall or a valid flag high during reset");
      fails++;
    end

  // Blocked entry must not move
  wb_steady: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid && wb_stall |=> wb_valid && $stable(wb_robid) && $stable(wb_rd)
                             && $stable(wb_result))
    else begin
      $error("writeback outputs changed while stalled");
      fails++;
    end

  stall_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    mcalu_valid && wb_valid && wb_stall |-> stall)
    else begin
      $error("stall low while the finished result is blocked");
      fails++;
    end

  flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !mcalu_valid)
    else begin
      $error("result offered right after a flush");
      fails++;
    end

endmodule

bind exec_unit_top exec_unit_props #(.robid_w(robid_w), .rd_w(rd_w)) u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush       (flush),
  .stall       (stall),
  .wb_stall    (wb_stall),
  .wb_valid    (wb_valid),
  .wb_robid    (wb_robid),
  .wb_rd       (wb_rd),
  .wb_result   (wb_result),
  .mcalu_valid (mcalu_valid)
);

`default_nettype wire

/* dv/tb_exec_unit.sv */
// Execution unit testbench
`default_nettype none
`timescale 1ns/100ps

module tb_exec_unit import mcalu_pkg::*; ();

  localparam int robid_w  = 7;
  localparam int rd_w     = 6;
  localparam int wait_max = 400;

  typedef struct packed {
    logic [robid_w-1:0] robid;
    logic [rd_w-1:0]    rd;
    logic [xlen-1:0]    result;
  } exp_t;

  logic               clk;
  logic               rst_n;
  logic               flush;
  logic               issue;
  mc_op_u             op;
  logic [robid_w-1:0] robid;
  logic [rd_w-1:0]    rd;
  logic [xlen-1:0]    op1;
  logic [xlen-1:0]    op2;
  logic               stall;
  logic               wb_stall;
  logic               wb_valid;
  logic [robid_w-1:0] wb_robid;
  logic [rd_w-1:0]    wb_rd;
  logic [xlen-1:0]    wb_result;

  exp_t               exp_q[$];
  integer             seed;
  integer             stall_seed;
  int                 errors;
  int                 checks;
  bit                 stall_mode;
  int                 stall_left;
  logic [robid_w-1:0] next_robid;

  exec_unit_top #(.robid_w(robid_w), .rd_w(rd_w)) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .issue     (issue),
    .op        (op),
    .robid     (robid),
    .rd        (rd),
    .op1       (op1),
    .op2       (op2),
    .stall     (stall),
    .wb_stall  (wb_stall),
    .wb_valid  (wb_valid),
    .wb_robid  (wb_robid),
    .wb_rd     (wb_rd),
    .wb_result (wb_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Expected value straight from the RV32 rules
  function automatic logic [xlen-1:0] ref_result(input logic [4:0] code,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [2*xlen-1:0]      sa;
    logic [2*xlen-1:0]      ua;
    logic [2*xlen-1:0]      sb;
    logic [2*xlen-1:0]      ub;
    logic [2*xlen-1:0]      p_ss;
    logic [2*xlen-1:0]      p_su;
    logic [2*xlen-1:0]      p_uu;
    logic signed [xlen-1:0] q_s;
    logic signed [xlen-1:0] r_s;
    logic                   ovf;
    sa   = {{xlen{a[xlen-1]}}, a};
    ua   = {{xlen{1'b0}}, a};
    sb   = {{xlen{b[xlen-1]}}, b};
    ub   = {{xlen{1'b0}}, b};
    p_ss = sa * sb;
    p_su = sa * ub;
    p_uu = ua * ub;
    ovf  = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
    q_s  = '0;
    r_s  = '0;
    if (b != '0 && !ovf) begin
      q_s = $signed(a) / $signed(b);  // Signed quotient, truncated
      r_s = $signed(a) % $signed(b);
    end
    case (code)
      op_add:    return a + b;
      op_sub:    return a - b;
      op_sll:    return a << b[4:0];
      op_slt:    return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      op_sltu:   return {{(xlen-1){1'b0}}, a < b};
      op_xor:    return a ^ b;
      op_srl:    return a >> b[4:0];
      op_sra:    return $signed(a) >>> b[4:0];
      op_or:     return a | b;
      op_and:    return a & b;
      op_pass:   return b;
      op_mul:    return p_uu[xlen-1:0];
      op_mulh:   return p_ss[2*xlen-1:xlen];
      op_mulhsu: return p_su[2*xlen-1:xlen];
      op_mulhu:  return p_uu[2*xlen-1:xlen];
      op_div:    return (b == '0) ? '1 : ovf ? a : q_s;
      op_divu:   return (b == '0) ? '1 : a / b;
      op_rem:    return (b == '0) ? a : ovf ? '0 : r_s;
      op_remu:   return (b == '0) ? a : a % b;
      default:   return '0;
    endcase
  endfunction

  // Random word, often a corner value
  function automatic logic [xlen-1:0] pick_operand();
    logic [xlen-1:0] r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    return '0;
      4'd1:    return '1;
      4'd2:    return {1'b1, {(xlen-1){1'b0}}};
      4'd3:    return 1;
      default: return $random(seed);
    endcase
  endfunction

  function automatic logic [4:0] pick_code();
    int k;
    k = $unsigned($random(seed)) % 19;
    return (k < 11) ? 5'(k) : 5'(k + 13);  // Skip the unused gap
  endfunction

  task automatic end_run();
    int prop_fails;
    prop_fails = uut.u_props.fails;
    $display("Results checked %0d, errors %0d, property failures %0d",
             checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic issue_op(input logic [4:0] code, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b);
    int n;
    op    = code;
    op1   = a;
    op2   = b;
    robid = next_robid;
    rd    = rd_w'($random(seed));
    issue = 1'b1;
    n     = 0;
    @(negedge clk);
    while (stall) begin
      n++;
      if (n > wait_max) begin
        $display("Timeout: operation with robid %0d was never accepted", next_robid);
        errors++;
        end_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    issue      = 1'b0;
    next_robid = next_robid + 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || wb_valid) begin
      n++;
      if (n > wait_max) begin
        $display("Timeout: %0d results still outstanding", exp_q.size());
        errors++;
        end_run();
      end
      @(posedge clk);
      #1;
    end
  endtask

  // Flushed op is the youngest entry, still in mcalu
  task automatic flush_current();
    flush = 1'b1;
    exp_q.delete(exp_q.size() - 1);
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  task automatic measure_latency();
    int n;
    n = 0;
    while (!wb_valid && n < 10) begin
      @(negedge clk);
      n++;
    end
    assert (n == 2) else begin
      $display("[FAIL] %0t wb_valid latency got %0d expected %0d", $time, n, 2);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic record_issue();
    exp_t e;
    e.robid  = robid;
    e.rd     = rd;
    e.result = ref_result(op.code, op1, op2);
    exp_q.push_back(e);
  endtask

  task automatic compare_beat();
    exp_t e;
    assert (exp_q.size() > 0) else begin
      $display("Result for robid %0d arrived with nothing outstanding", wb_robid);
      errors++;
    end
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      checks++;
      assert (wb_robid == e.robid) else begin
        $display("[FAIL] %0t wb_robid got %0h expected %0h", $time, wb_robid, e.robid);
        errors++;
      end
      assert (wb_rd == e.rd) else begin
        $display("[FAIL] %0t wb_rd got %0h expected %0h", $time, wb_rd, e.rd);
        errors++;
      end
      assert (wb_result == e.result) else begin
        $display("[FAIL] %0t wb_result got %0h expected %0h", $time, wb_result, e.result);
        errors++;
      end
    end
  endtask

  // Sample at the falling edge, inputs settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (wb_valid && !wb_stall) compare_beat();
      if (issue && !stall && !flush) record_issue();
    end
  end

  // Writeback back-pressure in random stretches
  always @(posedge clk) begin
    #1;
    if (!stall_mode) begin
      wb_stall = 1'b0;
    end else if (stall_left == 0) begin
      wb_stall   = ~wb_stall;
      stall_left = $unsigned($random(stall_seed)) % 8;
    end else begin
      stall_left--;
    end
  end

  initial begin
    seed       = 94;
    stall_seed = 94;
    errors     = 0;
    checks     = 0;
    stall_mode = 1'b0;
    stall_left = 0;
    next_robid = '0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    issue      = 1'b0;
    op         = '0;
    robid      = '0;
    rd         = '0;
    op1        = '0;
    op2        = '0;
    wb_stall   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int c = int'(op_add); c <= int'(op_pass); c++) begin
      repeat (4) issue_op(5'(c), pick_operand(), pick_operand());
    end
    wait_drain();
    issue_op(op_add, 32'd5, 32'd7);
    measure_latency();

    for (int c = int'(op_mul); c <= int'(op_mulhu); c++) begin
      repeat (6) issue_op(5'(c), pick_operand(), pick_operand());
    end
    for (int c = int'(op_div); c <= int'(op_remu); c++) begin
      repeat (6) issue_op(5'(c), pick_operand(), pick_operand());
      issue_op(5'(c), pick_operand(), '0);
      issue_op(5'(c), {1'b1, {(xlen-1){1'b0}}}, '1);
    end
    wait_drain();

    stall_mode = 1'b1;
    repeat (40) issue_op(pick_code(), pick_operand(), pick_operand());
    wait_drain();
    stall_mode = 1'b0;
    idle_cycles(2);

    issue_op(op_mulh, pick_operand(), pick_operand());
    idle_cycles(5);
    flush_current();
    issue_op(op_divu, pick_operand(), pick_operand());
    idle_cycles(10);
    flush_current();
    issue_op(op_rem, pick_operand(), pick_operand());
    issue_op(op_add, pick_operand(), pick_operand());
    wait_drain();
    end_run();
  end

endmodule

`default_nettype wire

/* hw/alu_simple.sv */
// Single-cycle integer ALU
`default_nettype none
`timescale 1ns/100ps

module alu_simple import mcalu_pkg::*; (
  input  mc_op_u            op,
  input  logic [xlen-1:0]   op1,
  input  logic [xlen-1:0]   op2,
  output logic [xlen-1:0]   result
);

  localparam int sh_w = $clog2(xlen);

  logic [sh_w-1:0] shamt;
  logic            lt_s;
  logic            lt_u;

  assign shamt = op2[sh_w-1:0];  // Low bits only
  assign lt_s  = $signed(op1) < $signed(op2);
  assign lt_u  = op1 < op2;

  always_comb begin
    case (op.code)
      op_add:  result = op1 + op2;
      op_sub:  result = op1 - op2;
      op_sll:  result = op1 << shamt;
      op_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      op_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      op_xor:  result = op1 ^ op2;
      op_srl:  result = op1 >> shamt;
      op_sra:  result = $unsigned($signed(op1) >>> shamt);
      op_or:   result = op1 | op2;
      op_and:  result = op1 & op2;
      op_pass: result = op2;
      default: result = '0;  // Multi-cycle codes land elsewhere
    endcase
  end

endmodule

`default_nettype wire

/* hw/div.sv */
// Iterative restoring divider
`default_nettype none
`timescale 1ns/100ps

module div import mcalu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              req,
  input  logic [1:0]        func,
  input  logic [xlen-1:0]   op1,
  input  logic [xlen-1:0]   op2,
  input  logic              hold,
  output logic              done,
  output logic [xlen-1:0]   result
);

  typedef enum logic [1:0] {s_idle, s_busy, s_fin} state_t;

  state_t                  state;
  logic [$clog2(xlen)-1:0] cnt;
  logic [xlen-1:0]         quo_q;
  logic [xlen-1:0]         rem_q;
  logic [xlen-1:0]         dvsr;
  logic [xlen:0]           trial;
  logic                    q_neg;
  logic                    r_neg;
  logic                    want_rem;
  logic                    is_signed;
  logic                    div_zero;
  logic [xlen-1:0]         mag1;
  logic [xlen-1:0]         mag2;
  logic [xlen-1:0]         quo_fix;
  logic [xlen-1:0]         rem_fix;

  assign is_signed = (func == op_div[1:0]) || (func == op_rem[1:0]);
  assign div_zero  = op2 == '0;
  assign mag1 = (is_signed && op1[xlen-1]) ? -op1 : op1;
  assign mag2 = (is_signed && op2[xlen-1]) ? -op2 : op2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      cnt   <= '0;
    end else if (flush) begin
      state <= s_idle;
      cnt   <= '0;
    end else begin
      case (state)
        s_idle: if (req) begin
          state <= s_busy;
          cnt   <= '0;
        end
        s_busy: begin
          cnt <= cnt + 1'b1;
          if (cnt == '1) state <= s_fin;
        end
        s_fin:   if (req && !hold) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  // Shift in next dividend bit and try subtracting
  assign trial = {rem_q, quo_q[xlen-1]} - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (state == s_idle && req) begin
      quo_q    <= mag1;
      rem_q    <= '0;
      dvsr     <= mag2;
      q_neg    <= is_signed & (op1[xlen-1] ^ op2[xlen-1]) & ~div_zero;  // Keep all ones on /0
      r_neg    <= is_signed & op1[xlen-1];
      want_rem <= (func == op_rem[1:0]) || (func == op_remu[1:0]);
    end else if (state == s_busy) begin
      if (!trial[xlen]) begin
        rem_q <= trial[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end else begin
        rem_q <= {rem_q[xlen-2:0], quo_q[xlen-1]};  // Restore
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end
    end
  end

  // Overflow case falls out of the magnitude path unchanged
  assign quo_fix = q_neg ? -quo_q : quo_q;
  assign rem_fix = r_neg ? -rem_q : rem_q;
  assign done    = state == s_fin;
  assign result  = want_rem ? rem_fix : quo_fix;

endmodule

`default_nettype wire

/* hw/exec_unit_top.sv */
// Execution unit with writeback stage
`default_nettype none
`timescale 1ns/100ps

module exec_unit_top import mcalu_pkg::*; #(
  parameter int robid_w = 7,
  parameter int rd_w    = 6
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               issue,
  input  mc_op_u             op,
  input  logic [robid_w-1:0] robid,
  input  logic [rd_w-1:0]    rd,
  input  logic [xlen-1:0]    op1,
  input  logic [xlen-1:0]    op2,
  output logic               stall,
  input  logic               wb_stall,
  output logic               wb_valid,
  output logic [robid_w-1:0] wb_robid,
  output logic [rd_w-1:0]    wb_rd,
  output logic [xlen-1:0]    wb_result
);

  logic               mcalu_valid;
  logic [robid_w-1:0] mcalu_robid;
  logic [rd_w-1:0]    mcalu_rd;
  logic [xlen-1:0]    mcalu_result;
  logic               hold;

  mcalu #(.robid_w(robid_w), .rd_w(rd_w)) u_mcalu (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue        (issue),
    .op           (op),
    .robid        (robid),
    .rd           (rd),
    .op1          (op1),
    .op2          (op2),
    .hold         (hold),
    .stall        (stall),
    .mcalu_valid  (mcalu_valid),
    .mcalu_robid  (mcalu_robid),
    .mcalu_rd     (mcalu_rd),
    .mcalu_result (mcalu_result)
  );

  wb_stage #(.robid_w(robid_w), .rd_w(rd_w)) u_wb (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_stall  (wb_stall),
    .in_valid  (mcalu_valid),
    .in_robid  (mcalu_robid),
    .in_rd     (mcalu_rd),
    .in_result (mcalu_result),
    .hold      (hold),
    .wb_valid  (wb_valid),
    .wb_robid  (wb_robid),
    .wb_rd     (wb_rd),
    .wb_result (wb_result)
  );

endmodule

`default_nettype wire

/* hw/mcalu.sv */
// Multi-cycle integer execution unit
`default_nettype none
`timescale 1ns/100ps

module mcalu import mcalu_pkg::*; #(
  parameter int robid_w = 7,
  parameter int rd_w    = 6
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               issue,
  input  mc_op_u             op,
  input  logic [robid_w-1:0] robid,
  input  logic [rd_w-1:0]    rd,
  input  logic [xlen-1:0]    op1,
  input  logic [xlen-1:0]    op2,
  input  logic               hold,
  output logic               stall,
  output logic               mcalu_valid,
  output logic [robid_w-1:0] mcalu_robid,
  output logic [rd_w-1:0]    mcalu_rd,
  output logic [xlen-1:0]    mcalu_result
);

  logic            valid;
  mc_op_u          op_q;
  logic [xlen-1:0] op1_q;
  logic [xlen-1:0] op2_q;
  logic            is_mc;
  logic            mul_req;
  logic            div_req;
  logic            mul_done;
  logic            div_done;
  logic            done;
  logic [xlen-1:0] sc_result;
  logic [xlen-1:0] mul_result;
  logic [xlen-1:0] div_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (flush) begin
      valid <= 1'b0;
    end else if (!stall) begin
      valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      op_q        <= op;
      mcalu_robid <= robid;
      mcalu_rd    <= rd;
      op1_q       <= op1;
      op2_q       <= op2;
    end
  end

  assign is_mc   = op_q.f.cls == cls_mc;
  assign mul_req = valid & is_mc & ~op_q.f.is_div;  // Level while latched
  assign div_req = valid & is_mc & op_q.f.is_div;
  assign done    = ~is_mc | (op_q.f.is_div ? div_done : mul_done);

  assign mcalu_valid = valid & done;
  assign stall       = valid & (~done | hold);

  always_comb begin
    if (!is_mc) mcalu_result = sc_result;
    else if (op_q.f.is_div) mcalu_result = div_result;
    else mcalu_result = mul_result;
  end

  alu_simple u_alu (
    .op     (op_q),
    .op1    (op1_q),
    .op2    (op2_q),
    .result (sc_result)
  );

  mul u_mul (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .req    (mul_req),
    .func   (op_q.f.func),
    .op1    (op1_q),
    .op2    (op2_q),
    .hold   (hold),
    .done   (mul_done),
    .result (mul_result)
  );

  div u_div (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .req    (div_req),
    .func   (op_q.f.func),
    .op1    (op1_q),
    .op2    (op2_q),
    .hold   (hold),
    .done   (div_done),
    .result (div_result)
  );

endmodule

`default_nettype wire

/* hw/mcalu_pkg.sv */
// Execution unit shared definitions
`default_nettype none

package mcalu_pkg;

  localparam int xlen = 32;

  // Field view of the opcode
  typedef struct packed {
    logic [1:0] cls;     // 3 = multi-cycle
    logic       is_div;  // Divider when set
    logic [1:0] func;    // Variant within the unit
  } mc_op_f_t;

  // One opcode word, decoded plain or by fields
  typedef union packed {
    logic [4:0] code;
    mc_op_f_t   f;
  } mc_op_u;

  localparam logic [1:0] cls_mc = 2'd3;

  // Single-cycle operations
  localparam logic [4:0] op_add    = 5'd0;
  localparam logic [4:0] op_sub    = 5'd1;
  localparam logic [4:0] op_sll    = 5'd2;
  localparam logic [4:0] op_slt    = 5'd3;
  localparam logic [4:0] op_sltu   = 5'd4;
  localparam logic [4:0] op_xor    = 5'd5;
  localparam logic [4:0] op_srl    = 5'd6;
  localparam logic [4:0] op_sra    = 5'd7;
  localparam logic [4:0] op_or     = 5'd8;
  localparam logic [4:0] op_and    = 5'd9;
  localparam logic [4:0] op_pass   = 5'd10;

  // Multiplier
  localparam logic [4:0] op_mul    = 5'd24;
  localparam logic [4:0] op_mulh   = 5'd25;
  localparam logic [4:0] op_mulhsu = 5'd26;
  localparam logic [4:0] op_mulhu  = 5'd27;

  // Divider
  localparam logic [4:0] op_div    = 5'd28;
  localparam logic [4:0] op_divu   = 5'd29;
  localparam logic [4:0] op_rem    = 5'd30;
  localparam logic [4:0] op_remu   = 5'd31;

endpackage

`default_nettype wire

/* hw/mul.sv */
// Iterative shift-add multiplier
`default_nettype none
`timescale 1ns/100ps

module mul import mcalu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              req,
  input  logic [1:0]        func,
  input  logic [xlen-1:0]   op1,
  input  logic [xlen-1:0]   op2,
  input  logic              hold,
  output logic              done,
  output logic [xlen-1:0]   result
);

  typedef enum logic [1:0] {s_idle, s_busy, s_fin} state_t;

  state_t                  state;
  logic [$clog2(xlen)-1:0] cnt;
  logic [xlen-1:0]         mcand;
  logic [2*xlen-1:0]       prod;
  logic [2*xlen-1:0]       prod_fix;
  logic [xlen:0]           sum;
  logic                    neg;
  logic                    want_hi;
  logic                    op1_signed;
  logic                    op2_signed;
  logic [xlen-1:0]         mag1;
  logic [xlen-1:0]         mag2;

  assign op1_signed = (func == op_mulh[1:0]) || (func == op_mulhsu[1:0]);
  assign op2_signed = (func == op_mulh[1:0]);
  assign mag1 = (op1_signed && op1[xlen-1]) ? -op1 : op1;
  assign mag2 = (op2_signed && op2[xlen-1]) ? -op2 : op2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      cnt   <= '0;
    end else if (flush) begin
      state <= s_idle;
      cnt   <= '0;
    end else begin
      case (state)
        s_idle: if (req) begin
          state <= s_busy;
          cnt   <= '0;
        end
        s_busy: begin
          cnt <= cnt + 1'b1;
          if (cnt == '1) state <= s_fin;  // 32 steps done
        end
        s_fin:   if (req && !hold) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  // Add multiplicand into upper half, then shift right
  assign sum = {1'b0, prod[2*xlen-1:xlen]} + (prod[0] ? {1'b0, mcand} : '0);

  always_ff @(posedge clk) begin
    if (state == s_idle && req) begin
      mcand   <= mag1;
      prod    <= {{xlen{1'b0}}, mag2};
      neg     <= (op1_signed & op1[xlen-1]) ^ (op2_signed & op2[xlen-1]);
      want_hi <= func != op_mul[1:0];
    end else if (state == s_busy) begin
      prod <= {sum, prod[xlen-1:1]};
    end
  end

  assign prod_fix = neg ? -prod : prod;
  assign done     = state == s_fin;
  assign result   = want_hi ? prod_fix[2*xlen-1:xlen] : prod_fix[xlen-1:0];

endmodule

`default_nettype wire

/* hw/wb_stage.sv */
// Writeback result register
`default_nettype none
`timescale 1ns/100ps

module wb_stage import mcalu_pkg::*; #(
  parameter int robid_w = 7,
  parameter int rd_w    = 6
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wb_stall,
  input  logic               in_valid,
  input  logic [robid_w-1:0] in_robid,
  input  logic [rd_w-1:0]    in_rd,
  input  logic [xlen-1:0]    in_result,
  output logic               hold,
  output logic               wb_valid,
  output logic [robid_w-1:0] wb_robid,
  output logic [rd_w-1:0]    wb_rd,
  output logic [xlen-1:0]    wb_result
);

  logic load;

  assign hold = wb_valid & wb_stall;  // Full and blocked
  assign load = in_valid & ~hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else if (load) begin
      wb_valid <= 1'b1;
    end else if (!wb_stall) begin
      wb_valid <= 1'b0;  // Drained, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      wb_robid  <= in_robid;
      wb_rd     <= in_rd;
      wb_result <= in_result;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and scan the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_exec_unit -o sim_exec_unit > build.log 2>&1 \
  && ./obj_dir/sim_exec_unit +verilator+error+limit+1000 > sim.log 2>&1 \
  && ! grep -q "SIMULATION FAILED" sim.log \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed, see build.log and sim.log"; exit 1; }

/* sources.f */
hw/mcalu_pkg.sv
hw/alu_simple.sv
hw/mul.sv
hw/div.sv
hw/mcalu.sv
hw/wb_stage.sv
hw/exec_unit_top.sv
dv/exec_unit_props.sv
dv/tb_exec_unit.sv
